// File: hdl/flash_geom_pkg.sv
package flash_geom_pkg;

    // address phase on the bus is always 24 bits, upper bits are dropped
    localparam int addr_bytes = 3;

    localparam int mem_bytes    = 65536;
    localparam int page_bytes   = 256;
    localparam int sector_bytes = 4096;

    // WIP hold time after the last programmed byte, in sclk cycles
    localparam int program_busy_cycles = 16;

    localparam int mem_addr_bits    = $clog2(mem_bytes);
    localparam int page_addr_bits   = $clog2(page_bytes);    // offset bits inside a page
    localparam int sector_addr_bits = $clog2(sector_bytes);  // offset bits inside a sector
    localparam int busy_cnt_bits    = $clog2(program_busy_cycles + 1);

    typedef logic [mem_addr_bits-1:0] mem_addr_t;
    typedef logic [busy_cnt_bits-1:0] busy_cnt_t;

endpackage

// File: hdl/qspi_cmd_pkg.sv
package qspi_cmd_pkg;

    // opcodes the device answers to
    typedef enum logic [7:0] {
        cmd_wrdi         = 8'h04,
        cmd_page_prog    = 8'h02,  // 1-1-1
        cmd_read         = 8'h03,
        cmd_read_status  = 8'h05,
        cmd_wren         = 8'h06,
        cmd_fast_read    = 8'h0B,
        cmd_sector_erase = 8'h20,
        cmd_quad_prog    = 8'h32,  // 1-1-4
        cmd_dual_read    = 8'h3B,  // 1-1-2
        cmd_read_id      = 8'h9F
    } qspi_opcode_e;

    // request kinds from the protocol engine to status and array
    typedef enum logic [2:0] {
        op_none,
        op_wren,
        op_wrdi,
        op_program,
        op_erase
    } flash_op_e;

    typedef enum logic [3:0] {
        st_cmd,
        st_addr,
        st_dummy,
        st_read,
        st_program,
        st_status,
        st_id,
        st_ignore
    } fsm_state_e;

    localparam logic [23:0] jedec_id = 24'hC22017;  // manufacturer, type, capacity
    localparam int id_bytes = 3;

    localparam int fast_read_dummy = 8;  // same for 0x0B and 0x3B

    localparam logic [2:0] lanes_single = 3'd1;
    localparam logic [2:0] lanes_dual   = 3'd2;
    localparam logic [2:0] lanes_quad   = 3'd4;

    localparam logic [3:0] oe_single = 4'b0010;  // so on io1
    localparam logic [3:0] oe_dual   = 4'b0011;

    typedef struct packed {
        logic [3:0] oe;
        logic [3:0] out;
    } qspi_pads_t;

    typedef struct packed {
        flash_op_e                 op;
        flash_geom_pkg::mem_addr_t addr;
        logic [7:0]                wdata;
    } flash_req_t;

endpackage

// File: hdl/flash_status_reg.sv
`timescale 1ns/1ps

module flash_status_reg (
    input  logic                     qspi_sclk,
    input  qspi_cmd_pkg::flash_req_t req,
    input  logic                     erase_done,
    output logic [7:0]               status_byte
);

    // all clear at power-up
    logic                      wel      = 1'b0;
    logic                      wip      = 1'b0;
    flash_geom_pkg::busy_cnt_t busy_cnt = '0;   // nonzero while a program is busy
    logic                      prog_end;

    // last busy cycle with no fresh byte arriving
    assign prog_end = (busy_cnt == flash_geom_pkg::busy_cnt_t'(1)) &&
                      (req.op != qspi_cmd_pkg::op_program);

    always_ff @(posedge qspi_sclk) begin
        if (req.op == qspi_cmd_pkg::op_program) begin
            busy_cnt <= flash_geom_pkg::busy_cnt_t'(flash_geom_pkg::program_busy_cycles);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end

        case (req.op)
            qspi_cmd_pkg::op_wren:    wel <= 1'b1;
            qspi_cmd_pkg::op_wrdi:    wel <= 1'b0;
            qspi_cmd_pkg::op_program: wip <= 1'b1;
            qspi_cmd_pkg::op_erase:   wip <= 1'b1;  // held until the sweep ends
            default: ;
        endcase

        // a finished program or erase drops the write enable as well
        if (prog_end || erase_done) begin
            wip <= 1'b0;
            wel <= 1'b0;
        end
    end

    assign status_byte = {6'b000000, wel, wip};

endmodule

// File: hdl/flash_array.sv
`timescale 1ns/1ps

module flash_array (
    input  logic                      qspi_sclk,
    input  qspi_cmd_pkg::flash_req_t  req,
    input  flash_geom_pkg::mem_addr_t rd_addr,
    output logic [7:0]                rd_data,
    output logic                      erase_done
);

    // erased flash reads all ones
    logic [7:0] mem [flash_geom_pkg::mem_bytes] = '{default: 8'hFF};

    logic                      erasing   = 1'b0;
    logic                      sweep_end = 1'b0;
    flash_geom_pkg::mem_addr_t erase_ptr;
    flash_geom_pkg::mem_addr_t sector_base;
    logic                      last_byte;

    assign sector_base = {req.addr[flash_geom_pkg::mem_addr_bits-1:flash_geom_pkg::sector_addr_bits],
                          {flash_geom_pkg::sector_addr_bits{1'b0}}};

    assign last_byte = erase_ptr[flash_geom_pkg::sector_addr_bits-1:0] == '1;

    assign rd_data = mem[rd_addr];  // async read

    // single write port, the sweep owns it while running
    always_ff @(posedge qspi_sclk) begin
        if (erasing) begin
            mem[erase_ptr] <= 8'hFF;
        end else if (req.op == qspi_cmd_pkg::op_program) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // sector sweep, one byte per clock from the sector base
    always_ff @(posedge qspi_sclk) begin
        sweep_end <= 1'b0;
        if (erasing) begin
            erase_ptr <= erase_ptr + 1'b1;
            if (last_byte) begin
                erasing   <= 1'b0;
                sweep_end <= 1'b1;  // pulses the cycle after the last clear
            end
        end else if (req.op == qspi_cmd_pkg::op_erase) begin
            erasing   <= 1'b1;
            erase_ptr <= sector_base;
        end
    end

    assign erase_done = sweep_end;

endmodule

// File: hdl/qspi_protocol_fsm.sv
`timescale 1ns/1ps

module qspi_protocol_fsm (
    input  logic                      qspi_sclk,
    input  logic                      qspi_cs_n,
    input  logic [3:0]                io_in,
    input  logic [7:0]                status_byte,
    input  logic [7:0]                rd_data,
    output qspi_cmd_pkg::flash_req_t  req,
    output flash_geom_pkg::mem_addr_t rd_addr,
    output qspi_cmd_pkg::qspi_pads_t  pads
);

    qspi_cmd_pkg::fsm_state_e   state;
    qspi_cmd_pkg::qspi_opcode_e cmd;
    logic [2:0]                 bit_cnt;    // bit position inside the current byte
    logic [1:0]                 byte_cnt;   // address or id byte index
    logic [2:0]                 lanes;
    logic [7:0]                 shift_in;
    logic [7:0]                 shift_out;
    flash_geom_pkg::mem_addr_t  addr;

    logic [7:0]                 in_next;
    flash_geom_pkg::mem_addr_t  addr_next;
    flash_geom_pkg::mem_addr_t  addr_in_page;
    logic                       byte_done;
    logic                       addr_done;
    logic                       dummy_done;
    logic                       wel;
    logic [7:0]                 id_byte;
    logic [7:0]                 load_byte;
    logic [7:0]                 cur_byte;
    logic [7:0]                 out_next;
    logic [3:0]                 pad_bits;

    assign wel = status_byte[1];

    // quad input takes a nibble per edge, high nibble first
    assign in_next = (lanes == qspi_cmd_pkg::lanes_quad) ? {shift_in[3:0], io_in}
                                                         : {shift_in[6:0], io_in[0]};

    assign addr_next = {addr[flash_geom_pkg::mem_addr_bits-2:0], io_in[0]};

    // program address wraps inside its page
    assign addr_in_page = {addr[flash_geom_pkg::mem_addr_bits-1:flash_geom_pkg::page_addr_bits],
                           addr[flash_geom_pkg::page_addr_bits-1:0] + 1'b1};

    assign byte_done  = ({1'b0, bit_cnt} + {1'b0, lanes}) == 4'd8;
    assign addr_done  = (bit_cnt == 3'd7) && (byte_cnt == 2'(flash_geom_pkg::addr_bytes - 1));
    assign dummy_done = bit_cnt == 3'(qspi_cmd_pkg::fast_read_dummy - 1);
    assign rd_addr    = addr;

    always_comb begin
        case (byte_cnt)
            2'd0:    id_byte = qspi_cmd_pkg::jedec_id[23:16];
            2'd1:    id_byte = qspi_cmd_pkg::jedec_id[15:8];
            default: id_byte = qspi_cmd_pkg::jedec_id[7:0];
        endcase
    end

    always_comb begin
        case (state)
            qspi_cmd_pkg::st_status: load_byte = status_byte;  // live value, every byte
            qspi_cmd_pkg::st_id:     load_byte = id_byte;
            default:                 load_byte = rd_data;
        endcase
    end

    // first chunk of a byte comes straight from the source, the rest from shift_out
    assign cur_byte = (bit_cnt == 3'd0) ? load_byte : shift_out;

    always_comb begin
        if (lanes == qspi_cmd_pkg::lanes_dual) begin
            out_next = {cur_byte[5:0], 2'b00};
            pad_bits = {2'b00, cur_byte[7:6]};  // upper bit of the pair on io1
        end else begin
            out_next = {cur_byte[6:0], 1'b0};
            pad_bits = {2'b00, cur_byte[7], 1'b0};
        end
    end

    // requests are strobes decoded from the bit that completes a field
    always_comb begin
        req.op    = qspi_cmd_pkg::op_none;
        req.addr  = addr;
        req.wdata = in_next;
        case (state)
            qspi_cmd_pkg::st_cmd: begin
                if (bit_cnt == 3'd7 && in_next == qspi_cmd_pkg::cmd_wren) begin
                    req.op = qspi_cmd_pkg::op_wren;
                end else if (bit_cnt == 3'd7 && in_next == qspi_cmd_pkg::cmd_wrdi) begin
                    req.op = qspi_cmd_pkg::op_wrdi;
                end
            end
            qspi_cmd_pkg::st_addr: begin
                req.addr = addr_next;
                if (addr_done && cmd == qspi_cmd_pkg::cmd_sector_erase) begin
                    req.op = qspi_cmd_pkg::op_erase;
                end
            end
            qspi_cmd_pkg::st_program: begin
                if (byte_done) req.op = qspi_cmd_pkg::op_program;
            end
            default: ;
        endcase
    end

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            state    <= qspi_cmd_pkg::st_cmd;
            cmd      <= qspi_cmd_pkg::cmd_read;
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
            lanes    <= qspi_cmd_pkg::lanes_single;
            pads     <= '0;
        end else begin
            case (state)
                qspi_cmd_pkg::st_cmd: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        byte_cnt <= 2'd0;
                        cmd      <= qspi_cmd_pkg::qspi_opcode_e'(in_next);
                        case (in_next)
                            qspi_cmd_pkg::cmd_read_id:     state <= qspi_cmd_pkg::st_id;
                            qspi_cmd_pkg::cmd_read_status: state <= qspi_cmd_pkg::st_status;
                            qspi_cmd_pkg::cmd_read,
                            qspi_cmd_pkg::cmd_fast_read:   state <= qspi_cmd_pkg::st_addr;
                            qspi_cmd_pkg::cmd_dual_read: begin
                                state <= qspi_cmd_pkg::st_addr;
                                lanes <= qspi_cmd_pkg::lanes_dual;
                            end
                            qspi_cmd_pkg::cmd_page_prog,
                            qspi_cmd_pkg::cmd_sector_erase: begin
                                state <= wel ? qspi_cmd_pkg::st_addr : qspi_cmd_pkg::st_ignore;
                            end
                            qspi_cmd_pkg::cmd_quad_prog: begin
                                state <= wel ? qspi_cmd_pkg::st_addr : qspi_cmd_pkg::st_ignore;
                                lanes <= qspi_cmd_pkg::lanes_quad;  // data phase only
                            end
                            default: state <= qspi_cmd_pkg::st_ignore;  // wren, wrdi, unknown
                        endcase
                    end
                end
                qspi_cmd_pkg::st_addr: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) byte_cnt <= byte_cnt + 1'b1;
                    if (addr_done) begin
                        byte_cnt <= 2'd0;
                        case (cmd)
                            qspi_cmd_pkg::cmd_read:      state <= qspi_cmd_pkg::st_read;
                            qspi_cmd_pkg::cmd_fast_read,
                            qspi_cmd_pkg::cmd_dual_read: state <= qspi_cmd_pkg::st_dummy;
                            qspi_cmd_pkg::cmd_page_prog,
                            qspi_cmd_pkg::cmd_quad_prog: state <= qspi_cmd_pkg::st_program;
                            default:                     state <= qspi_cmd_pkg::st_ignore;
                        endcase
                    end
                end
                qspi_cmd_pkg::st_dummy: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (dummy_done) begin
                        bit_cnt <= 3'd0;
                        state   <= qspi_cmd_pkg::st_read;
                    end
                end
                qspi_cmd_pkg::st_read,
                qspi_cmd_pkg::st_status,
                qspi_cmd_pkg::st_id: begin
                    pads.out <= pad_bits;
                    pads.oe  <= (lanes == qspi_cmd_pkg::lanes_dual) ? qspi_cmd_pkg::oe_dual
                                                                   : qspi_cmd_pkg::oe_single;
                    bit_cnt  <= byte_done ? 3'd0 : bit_cnt + lanes;
                    if (state == qspi_cmd_pkg::st_id && byte_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // last id bit stays on io1 for one more cycle
                        if (byte_cnt == 2'(qspi_cmd_pkg::id_bytes - 1)) begin
                            state <= qspi_cmd_pkg::st_ignore;
                        end
                    end
                end
                qspi_cmd_pkg::st_program: begin
                    bit_cnt <= byte_done ? 3'd0 : bit_cnt + lanes;
                end
                default: begin
                    pads.oe <= 4'b0000;  // wait for CS# high
                end
            endcase
        end
    end

    always_ff @(posedge qspi_sclk) begin
        case (state)
            qspi_cmd_pkg::st_cmd:  shift_in <= in_next;
            qspi_cmd_pkg::st_addr: addr <= addr_next;  // keeps the low 16 of 24 bits
            qspi_cmd_pkg::st_read: begin
                shift_out <= out_next;
                if (byte_done) addr <= addr + 1'b1;
            end
            qspi_cmd_pkg::st_status,
            qspi_cmd_pkg::st_id:   shift_out <= out_next;
            qspi_cmd_pkg::st_program: begin
                shift_in <= in_next;
                if (byte_done) addr <= addr_in_page;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/qspi_flash_top.sv
`timescale 1ns/1ps

module qspi_flash_top (
    input  logic                     qspi_sclk,
    input  logic                     qspi_cs_n,
    input  logic [3:0]               io_in,      // io3..io0
    output qspi_cmd_pkg::qspi_pads_t pads
);

    qspi_cmd_pkg::flash_req_t  req;
    flash_geom_pkg::mem_addr_t rd_addr;
    logic [7:0]                rd_data;
    logic [7:0]                status_byte;
    logic                      erase_done;

    // serial side, the only block reset by CS# high
    qspi_protocol_fsm u_fsm (
        .qspi_sclk   (qspi_sclk),
        .qspi_cs_n   (qspi_cs_n),
        .io_in       (io_in),
        .status_byte (status_byte),
        .rd_data     (rd_data),
        .req         (req),
        .rd_addr     (rd_addr),
        .pads        (pads)
    );

    flash_status_reg u_status (
        .qspi_sclk   (qspi_sclk),
        .req         (req),
        .erase_done  (erase_done),
        .status_byte (status_byte)
    );

    flash_array u_array (
        .qspi_sclk  (qspi_sclk),
        .req        (req),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .erase_done (erase_done)
    );

endmodule

// File: verif/qspi_host_tasks.svh
// host side of the serial bus, included into the testbench top

// msb first on io0, each bit set up 1 ns after a rising edge
task automatic send_bits(input logic [23:0] value, input int nbits);
    logic [23:0] v;
    v = value << (24 - nbits);
    for (int i = 0; i < nbits; i++) begin
        io_in = {3'b000, v[23]};
        v     = v << 1;
        @(posedge qspi_sclk);
        #1;
    end
endtask

// high nibble first on io3..io0
task automatic send_quad(input logic [7:0] d);
    io_in = d[7:4];
    @(posedge qspi_sclk);
    #1;
    io_in = d[3:0];
    @(posedge qspi_sclk);
    #1;
endtask

task automatic start_cmd(input logic [7:0] op);
    qspi_cs_n = 1'b0;
    send_bits({16'h0000, op}, 8);
endtask

task automatic send_addr(input logic [15:0] addr);
    send_bits({8'h00, addr}, 24);  // top byte is beyond the 64 KiB array
endtask

// device changes pads after the rising edge, so sample on the falling one
task automatic recv_byte(input logic dual, output logic [7:0] b);
    int nsamp;
    nsamp = dual ? 4 : 8;
    b     = 8'h00;
    for (int i = 0; i < nsamp; i++) begin
        @(posedge qspi_sclk);
        @(negedge qspi_sclk);
        if (dual)
            b = {b[5:0], pads.out[1:0]};  // upper bit of the pair on io1
        else
            b = {b[6:0], pads.out[1]};
        if (i == 0) check_val("pads.oe", {4'h0, pads.oe}, dual ? 8'h03 : 8'h02);
    end
endtask

// CS# high for 3 cycles, pads must be released meanwhile
task automatic cs_release();
    @(posedge qspi_sclk);
    #1;
    qspi_cs_n = 1'b1;
    io_in     = 4'h0;
    repeat (3) @(posedge qspi_sclk);
    #1;
    check_val("pads.oe", {4'h0, pads.oe}, 8'h00);
endtask

task automatic simple_cmd(input logic [7:0] op);
    start_cmd(op);
    cs_release();
endtask

task automatic read_status(output logic [7:0] s);
    start_cmd(qspi_cmd_pkg::cmd_read_status);
    recv_byte(1'b0, s);
    cs_release();
endtask

task automatic program_page(input logic [7:0] op, input logic [15:0] addr,
                            input logic [7:0] data [$]);
    start_cmd(op);
    send_addr(addr);
    foreach (data[i]) begin
        if (op == qspi_cmd_pkg::cmd_quad_prog)
            send_quad(data[i]);
        else
            send_bits({16'h0000, data[i]}, 8);
    end
    cs_release();
endtask

task automatic erase_sector(input logic [15:0] addr);
    start_cmd(qspi_cmd_pkg::cmd_sector_erase);
    send_addr(addr);
    cs_release();
endtask

// File: verif/tb_qspi_flash.sv
`timescale 1ns/1ps

module tb_qspi_flash;

    localparam int max_polls = 500;  // erase sweep needs about 200 polls

    logic                     qspi_sclk;
    logic                     qspi_cs_n;
    logic [3:0]               io_in;
    qspi_cmd_pkg::qspi_pads_t pads;

    logic [7:0] model [65536] = '{default: 8'hFF};  // expected array contents
    logic [7:0] id_exp [3] = '{8'hC2, 8'h20, 8'h17};
    logic [7:0] wbuf [$];
    logic [7:0] st;
    int         seed;
    int         errors;
    int         checks;

    qspi_flash_top uut (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .io_in     (io_in),
        .pads      (pads)
    );

    always #5 qspi_sclk = ~qspi_sclk;

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic expect_status(input logic [7:0] exp);
        read_status(st);
        check_val("status_byte", st, exp);
    endtask

    // random bytes, model updated with the page wrap only if WEL was set
    task automatic program_random(input logic [7:0] op, input logic [15:0] addr,
                                  input int n, input logic accepted);
        int         rnd;
        logic [7:0] offs;
        wbuf.delete();
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            wbuf.push_back(rnd[7:0]);
        end
        program_page(op, addr, wbuf);
        offs = addr[7:0];
        foreach (wbuf[i]) begin
            if (accepted) model[{addr[15:8], offs}] = wbuf[i];
            offs = offs + 8'd1;
        end
    endtask

    task automatic wait_ready();
        int polls;
        polls = 0;
        st    = 8'h01;
        while (st[0] && polls < max_polls) begin
            read_status(st);
            polls++;
        end
        if (st[0]) begin
            errors++;
            $display("wait for WIP to clear timed out after %0d status polls", polls);
        end
    endtask

    task automatic verify_read(input logic [7:0] op, input logic [15:0] addr, input int n);
        logic [7:0]  b;
        logic [15:0] a;
        start_cmd(op);
        send_addr(addr);
        if (op != qspi_cmd_pkg::cmd_read) send_bits(24'h0, 8);  // dummy cycles
        for (int i = 0; i < n; i++) begin
            a = addr + 16'(i);
            recv_byte(op == qspi_cmd_pkg::cmd_dual_read, b);
            check_val($sformatf("rd_data[0x%h]", a), b, model[a]);
        end
        cs_release();
    endtask

    `include "qspi_host_tasks.svh"

    initial begin
        qspi_sclk = 1'b0;
        qspi_cs_n = 1'b1;
        io_in     = 4'h0;
        seed      = 75;
        errors    = 0;
        checks    = 0;
        repeat (3) @(posedge qspi_sclk);
        #1;
        check_val("pads.oe", {4'h0, pads.oe}, 8'h00);

        // jedec id, io1 released after the third byte
        start_cmd(qspi_cmd_pkg::cmd_read_id);
        for (int i = 0; i < 3; i++) begin
            recv_byte(1'b0, st);
            check_val($sformatf("id byte %0d", i), st, id_exp[i]);
        end
        @(posedge qspi_sclk);
        @(negedge qspi_sclk);
        check_val("pads.oe", {4'h0, pads.oe}, 8'h00);
        cs_release();

        simple_cmd(qspi_cmd_pkg::cmd_wren);
        expect_status(8'h02);
        simple_cmd(qspi_cmd_pkg::cmd_wrdi);
        expect_status(8'h00);
        program_random(qspi_cmd_pkg::cmd_page_prog, 16'h1010, 4, 1'b0);  // refused
        expect_status(8'h00);
        verify_read(qspi_cmd_pkg::cmd_read, 16'h1010, 4);

        // crosses the page end and wraps to 0x2000
        simple_cmd(qspi_cmd_pkg::cmd_wren);
        program_random(qspi_cmd_pkg::cmd_page_prog, 16'h20FC, 8, 1'b1);
        expect_status(8'h03);
        wait_ready();
        expect_status(8'h00);
        verify_read(qspi_cmd_pkg::cmd_read, 16'h2000, 256);

        simple_cmd(qspi_cmd_pkg::cmd_wren);
        program_random(qspi_cmd_pkg::cmd_quad_prog, 16'h5010, 16, 1'b1);
        wait_ready();
        verify_read(qspi_cmd_pkg::cmd_fast_read, 16'h5010, 16);
        verify_read(qspi_cmd_pkg::cmd_dual_read, 16'h5010, 16);

        // erase 0x3000 sector, the byte at 0x4000 must survive
        simple_cmd(qspi_cmd_pkg::cmd_wren);
        program_random(qspi_cmd_pkg::cmd_page_prog, 16'h3100, 2, 1'b1);
        wait_ready();
        simple_cmd(qspi_cmd_pkg::cmd_wren);
        program_random(qspi_cmd_pkg::cmd_page_prog, 16'h4000, 1, 1'b1);
        wait_ready();
        verify_read(qspi_cmd_pkg::cmd_read, 16'h3100, 2);
        simple_cmd(qspi_cmd_pkg::cmd_wren);
        erase_sector(16'h3456);
        for (int i = 0; i < 4096; i++) model[16'h3000 + 16'(i)] = 8'hFF;
        expect_status(8'h03);
        wait_ready();
        expect_status(8'h00);
        verify_read(qspi_cmd_pkg::cmd_read, 16'h3000, 4097);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verif
hdl/flash_geom_pkg.sv
hdl/qspi_cmd_pkg.sv
hdl/flash_status_reg.sv
hdl/flash_array.sv
hdl/qspi_protocol_fsm.sv
hdl/qspi_flash_top.sv
verif/tb_qspi_flash.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_qspi_flash \
    -f verilog.f -o tb_qspi_flash

out="$(./obj_dir/tb_qspi_flash)"
printf '%s\n' "$out"

echo "$out" | grep -qx "TEST RESULT: PASS"
